//--- common/led_driver_pkg.sv
`default_nettype none

package led_driver_pkg;

    // One bit per driver chain
    localparam int LANES = 30;

    typedef logic [LANES-1:0] lane_word_t;

    // Three 16 bit channels per column
    localparam int COLUMN_BITS = 48;

    // Wide enough for both buffer addresses and shift counts
    localparam int ADDR_W = 6;

    // Configuration register length of the driver chips
    localparam int CONF_BITS = 48;

    // Shifted MSB first, identical on every chain
    localparam logic [CONF_BITS-1:0] CONF_WORD = 48'h8000_0A3F_F1C0;

    // Driver signal pacing
    localparam int CLK_DIV = 4;
    localparam int CLK_DIV_W = $clog2(CLK_DIV);

    // Controller sequence
    typedef enum logic [2:0] {
        ST_IDLE         = 3'd0,
        ST_CONFIGURE    = 3'd1,
        ST_CONF_LATCH   = 3'd2,
        ST_STREAM_WAIT  = 3'd3,
        ST_COLUMN_SHIFT = 3'd4,
        ST_COLUMN_LATCH = 3'd5
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- src/clock_enable.sv
`timescale 1ns/10ps
`default_nettype none

module clock_enable (
    input  logic clk,
    input  logic nrst,
    output logic clk_enable
);

    logic [led_driver_pkg::CLK_DIV_W-1:0] div_cnt;

    // One pulse per rollover
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            div_cnt    <= '0;
            clk_enable <= 1'b0;
        end else begin
            if (div_cnt == led_driver_pkg::CLK_DIV_W'(led_driver_pkg::CLK_DIV - 1)) begin
                div_cnt    <= '0;
                clk_enable <= 1'b1;
            end else begin
                div_cnt    <= div_cnt + 1'b1;
                clk_enable <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/column_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module column_buffer (
    input  logic                                clk,
    input  logic                                nrst,
    input  logic                                we,
    input  logic [led_driver_pkg::ADDR_W-1:0]   waddr,
    input  led_driver_pkg::lane_word_t          wdata,
    input  logic                                bank_swap,
    input  logic [led_driver_pkg::ADDR_W-1:0]   raddr,
    output led_driver_pkg::lane_word_t          rdata
);

    led_driver_pkg::lane_word_t mem [2][led_driver_pkg::COLUMN_BITS];

    // Bank currently read by the controller
    logic front_sel;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            front_sel <= 1'b0;
        end else if (bank_swap) begin
            front_sel <= ~front_sel;
        end
    end

    // Host always lands in the back bank
    always_ff @(posedge clk) begin
        if (we) begin
            mem[~front_sel][waddr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        rdata <= mem[front_sel][raddr];
    end

    wr_addr_in_range: assert property (
        @(posedge clk) disable iff (!nrst)
        we |-> (waddr < led_driver_pkg::ADDR_W'(led_driver_pkg::COLUMN_BITS))
    );

    rd_addr_in_range: assert property (
        @(posedge clk) disable iff (!nrst)
        raddr < led_driver_pkg::ADDR_W'(led_driver_pkg::COLUMN_BITS)
    );

endmodule

`default_nettype wire

//--- driver/driver_serializer.sv
`timescale 1ns/10ps
`default_nettype none

module driver_serializer (
    input  logic                                clk,
    input  logic                                nrst,
    input  logic                                clk_enable,
    input  logic                                start,
    input  logic [led_driver_pkg::ADDR_W-1:0]   shift_count,
    input  led_driver_pkg::lane_word_t          word,
    output logic                                word_req,
    output logic [led_driver_pkg::ADDR_W-1:0]   word_idx,
    output logic                                sclk,
    output logic                                lat,
    output led_driver_pkg::lane_word_t          sin,
    output logic                                done
);

    logic                               busy;
    logic                               first;
    logic                               armed;
    logic                               phase;
    logic                               latching;
    logic                               req_d;
    logic [led_driver_pkg::ADDR_W-1:0]  bit_cnt;
    logic [led_driver_pkg::ADDR_W-1:0]  last_idx;
    led_driver_pkg::lane_word_t         next_q;

    // Requested word shows up one cycle after word_req
    always_ff @(posedge clk) begin
        if (req_d) begin
            if (first) begin
                sin <= word;
            end else begin
                next_q <= word;
            end
        end
        if (busy && clk_enable && armed && phase && !latching && bit_cnt != last_idx) begin
            sin <= next_q;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            busy     <= 1'b0;
            first    <= 1'b0;
            armed    <= 1'b0;
            phase    <= 1'b0;
            latching <= 1'b0;
            req_d    <= 1'b0;
            bit_cnt  <= '0;
            last_idx <= '0;
            word_req <= 1'b0;
            word_idx <= '0;
            sclk     <= 1'b0;
            lat      <= 1'b0;
            done     <= 1'b0;
        end else begin
            word_req <= 1'b0;
            done     <= 1'b0;
            req_d    <= word_req;

            if (req_d && first) begin
                first <= 1'b0;
            end

            if (start && !busy) begin
                busy     <= 1'b1;
                first    <= 1'b1;
                armed    <= 1'b0;
                phase    <= 1'b0;
                bit_cnt  <= '0;
                last_idx <= shift_count - 1'b1;
                word_req <= 1'b1;
                word_idx <= '0;
            end else if (busy && clk_enable && !first) begin
                if (!armed) begin
                    // Setup tick for the first bit
                    armed <= 1'b1;
                end else if (latching) begin
                    lat      <= 1'b0;
                    latching <= 1'b0;
                    busy     <= 1'b0;
                    armed    <= 1'b0;
                    done     <= 1'b1;
                end else if (!phase) begin
                    sclk  <= 1'b1;
                    phase <= 1'b1;
                    // Fetch ahead during the high half
                    if (bit_cnt != last_idx) begin
                        word_req <= 1'b1;
                        word_idx <= bit_cnt + 1'b1;
                    end
                end else begin
                    sclk  <= 1'b0;
                    phase <= 1'b0;
                    if (bit_cnt == last_idx) begin
                        lat      <= 1'b1;
                        latching <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            end
        end
    end

    lat_sclk_exclusive: assert property (
        @(posedge clk) disable iff (!nrst)
        !(lat && sclk)
    );

endmodule

`default_nettype wire

//--- driver/driver_controller.sv
`timescale 1ns/10ps
`default_nettype none

module driver_controller (
    input  logic                                clk,
    input  logic                                nrst,
    input  logic                                clk_enable,
    input  logic                                new_configuration_ready,
    input  logic                                position_sync,
    input  led_driver_pkg::lane_word_t          buffer_rdata,
    output logic [led_driver_pkg::ADDR_W-1:0]   buffer_raddr,
    output logic                                bank_swap,
    output logic                                drv_sclk,
    output logic                                drv_lat,
    output led_driver_pkg::lane_word_t          drv_sin,
    output logic                                gclk_run,
    output logic                                column_ready,
    output logic                                driver_ready
);

    led_driver_pkg::ctrl_state_t state;

    logic                               ser_start;
    logic [led_driver_pkg::ADDR_W-1:0]  ser_count;
    logic                               ser_word_req;
    logic [led_driver_pkg::ADDR_W-1:0]  ser_word_idx;
    logic                               ser_done;
    led_driver_pkg::lane_word_t         ser_word;
    led_driver_pkg::lane_word_t         conf_q;
    logic                               sync_pending;

    // Configuration bit for the requested index, copied to every lane
    always_ff @(posedge clk) begin
        if (ser_word_req) begin
            conf_q <= {led_driver_pkg::LANES{
                led_driver_pkg::CONF_WORD[led_driver_pkg::CONF_BITS - 1 - int'(ser_word_idx)]}};
        end
    end

    assign ser_word     = (state == led_driver_pkg::ST_CONFIGURE) ? conf_q : buffer_rdata;
    assign buffer_raddr = ser_word_idx;
    assign driver_ready = (state == led_driver_pkg::ST_STREAM_WAIT);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state        <= led_driver_pkg::ST_IDLE;
            ser_start    <= 1'b0;
            ser_count    <= '0;
            bank_swap    <= 1'b0;
            gclk_run     <= 1'b0;
            column_ready <= 1'b0;
            sync_pending <= 1'b0;
        end else begin
            ser_start    <= 1'b0;
            bank_swap    <= 1'b0;
            column_ready <= 1'b0;

            unique case (state)
                led_driver_pkg::ST_IDLE: begin
                    if (new_configuration_ready) begin
                        ser_start <= 1'b1;
                        ser_count <= led_driver_pkg::ADDR_W'(led_driver_pkg::CONF_BITS);
                        state     <= led_driver_pkg::ST_CONFIGURE;
                    end
                end
                led_driver_pkg::ST_CONFIGURE: begin
                    if (drv_lat) begin
                        state <= led_driver_pkg::ST_CONF_LATCH;
                    end
                end
                led_driver_pkg::ST_CONF_LATCH: begin
                    if (ser_done) begin
                        gclk_run <= 1'b1;
                        state    <= led_driver_pkg::ST_STREAM_WAIT;
                    end
                end
                led_driver_pkg::ST_STREAM_WAIT: begin
                    if (position_sync || sync_pending) begin
                        sync_pending <= 1'b0;
                        bank_swap    <= 1'b1;
                        ser_start    <= 1'b1;
                        ser_count    <= led_driver_pkg::ADDR_W'(led_driver_pkg::COLUMN_BITS);
                        state        <= led_driver_pkg::ST_COLUMN_SHIFT;
                    end
                end
                led_driver_pkg::ST_COLUMN_SHIFT: begin
                    // Only one sync is kept while busy
                    if (position_sync) begin
                        sync_pending <= 1'b1;
                    end
                    if (drv_lat) begin
                        state <= led_driver_pkg::ST_COLUMN_LATCH;
                    end
                end
                led_driver_pkg::ST_COLUMN_LATCH: begin
                    if (position_sync) begin
                        sync_pending <= 1'b1;
                    end
                    if (ser_done) begin
                        column_ready <= 1'b1;
                        state        <= led_driver_pkg::ST_STREAM_WAIT;
                    end
                end
                default: begin
                    state <= led_driver_pkg::ST_IDLE;
                end
            endcase
        end
    end

    driver_serializer u_serializer (
        .clk         (clk),
        .nrst        (nrst),
        .clk_enable  (clk_enable),
        .start       (ser_start),
        .shift_count (ser_count),
        .word        (ser_word),
        .word_req    (ser_word_req),
        .word_idx    (ser_word_idx),
        .sclk        (drv_sclk),
        .lat         (drv_lat),
        .sin         (drv_sin),
        .done        (ser_done)
    );

    // Banks only trade places while the chains are quiet
    swap_from_stream_wait: assert property (
        @(posedge clk) disable iff (!nrst)
        bank_swap |-> $past(driver_ready) && !drv_sclk && !drv_lat
    );

    ready_after_column_latch: assert property (
        @(posedge clk) disable iff (!nrst)
        column_ready |-> $past(state == led_driver_pkg::ST_COLUMN_LATCH) && $past(drv_lat, 2)
    );

endmodule

`default_nettype wire

//--- driver/gclk_generator.sv
`timescale 1ns/10ps
`default_nettype none

module gclk_generator (
    input  logic clk,
    input  logic nrst,
    input  logic clk_enable,
    input  logic gclk_run,
    output logic gclk
);

    // Keeps toggling until low again once run drops
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            gclk <= 1'b0;
        end else if (clk_enable && (gclk_run || gclk)) begin
            gclk <= ~gclk;
        end
    end

endmodule

`default_nettype wire

//--- src/led_wall.sv
`timescale 1ns/10ps
`default_nettype none

module led_wall (
    input  logic                                clk,
    input  logic                                nrst,
    input  logic                                new_configuration_ready,
    input  logic                                position_sync,
    input  logic                                buf_we,
    input  logic [led_driver_pkg::ADDR_W-1:0]   buf_addr,
    input  led_driver_pkg::lane_word_t          buf_wdata,
    output logic                                drv_sclk,
    output logic                                drv_lat,
    output logic                                drv_gclk,
    output led_driver_pkg::lane_word_t          drv_sin,
    output logic                                column_ready,
    output logic                                driver_ready
);

    logic                               clk_enable;
    logic                               bank_swap;
    logic                               gclk_run;
    logic [led_driver_pkg::ADDR_W-1:0]  buffer_raddr;
    led_driver_pkg::lane_word_t         buffer_rdata;

    clock_enable u_clock_enable (
        .clk        (clk),
        .nrst       (nrst),
        .clk_enable (clk_enable)
    );

    column_buffer u_column_buffer (
        .clk       (clk),
        .nrst      (nrst),
        .we        (buf_we),
        .waddr     (buf_addr),
        .wdata     (buf_wdata),
        .bank_swap (bank_swap),
        .raddr     (buffer_raddr),
        .rdata     (buffer_rdata)
    );

    driver_controller u_driver_controller (
        .clk                     (clk),
        .nrst                    (nrst),
        .clk_enable              (clk_enable),
        .new_configuration_ready (new_configuration_ready),
        .position_sync           (position_sync),
        .buffer_rdata            (buffer_rdata),
        .buffer_raddr            (buffer_raddr),
        .bank_swap               (bank_swap),
        .drv_sclk                (drv_sclk),
        .drv_lat                 (drv_lat),
        .drv_sin                 (drv_sin),
        .gclk_run                (gclk_run),
        .column_ready            (column_ready),
        .driver_ready            (driver_ready)
    );

    gclk_generator u_gclk_generator (
        .clk        (clk),
        .nrst       (nrst),
        .clk_enable (clk_enable),
        .gclk_run   (gclk_run),
        .gclk       (drv_gclk)
    );

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic nrst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release a little after the edge so the first active cycle is clean
    initial begin
        nrst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        nrst = 1'b1;
    end

endmodule

`default_nettype wire

//--- bench/led_wall_tb.sv
`timescale 1ns/10ps
`default_nettype none

module led_wall_tb;

    localparam int BIT_CLOCKS = 2 * led_driver_pkg::CLK_DIV;
    localparam int WATCHDOG_CYCLES =
        5 * (led_driver_pkg::CONF_BITS + 4 * led_driver_pkg::COLUMN_BITS) * BIT_CLOCKS;
    localparam int WAIT_LIMIT = 4 * led_driver_pkg::COLUMN_BITS * BIT_CLOCKS;

    logic                               clk;
    logic                               nrst;
    logic                               new_configuration_ready;
    logic                               position_sync;
    logic                               buf_we;
    logic [led_driver_pkg::ADDR_W-1:0]  buf_addr;
    led_driver_pkg::lane_word_t         buf_wdata;
    logic                               drv_sclk;
    logic                               drv_lat;
    logic                               drv_gclk;
    led_driver_pkg::lane_word_t         drv_sin;
    logic                               column_ready;
    logic                               driver_ready;

    integer seed = 32'h63ce_7edf;
    int test_errors = 0;
    int total_errors = 0;
    int failed_tests = 0;
    string current_test = "";

    // Everything the monitor has seen so far
    led_driver_pkg::lane_word_t captured [$];
    led_driver_pkg::lane_word_t written [2][led_driver_pkg::COLUMN_BITS];
    int lat_pulses = 0;
    int ready_cycles = 0;
    int gclk_rises = 0;
    logic sclk_q = 1'b0;
    logic lat_q = 1'b0;
    logic gclk_q = 1'b0;

    tb_clock #(.PERIOD(4), .RESET_CYCLES(3)) u_clock (
        .clk  (clk),
        .nrst (nrst)
    );

    led_wall DUT (
        .clk                     (clk),
        .nrst                    (nrst),
        .new_configuration_ready (new_configuration_ready),
        .position_sync           (position_sync),
        .buf_we                  (buf_we),
        .buf_addr                (buf_addr),
        .buf_wdata               (buf_wdata),
        .drv_sclk                (drv_sclk),
        .drv_lat                 (drv_lat),
        .drv_gclk                (drv_gclk),
        .drv_sin                 (drv_sin),
        .column_ready            (column_ready),
        .driver_ready            (driver_ready)
    );

    // Edges found against the previous clock sample
    always @(posedge clk) begin
        if (drv_sclk && !sclk_q) begin
            captured.push_back(drv_sin);
        end
        if (drv_lat && !lat_q) begin
            lat_pulses++;
        end
        if (column_ready) begin
            ready_cycles++;
        end
        if (drv_gclk && !gclk_q) begin
            gclk_rises++;
        end
        sclk_q = drv_sclk;
        lat_q = drv_lat;
        gclk_q = drv_gclk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d clock cycles, run stopped", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic pulse_sync();
        position_sync = 1'b1;
        next_cycle();
        position_sync = 1'b0;
    endtask

    task automatic write_column(input int which);
        for (int i = 0; i < led_driver_pkg::COLUMN_BITS; i++) begin
            written[which][i] = led_driver_pkg::lane_word_t'($random(seed));
            buf_we = 1'b1;
            buf_addr = led_driver_pkg::ADDR_W'(i);
            buf_wdata = written[which][i];
            next_cycle();
        end
        buf_we = 1'b0;
    endtask

    // Waits for shifted bits and column_ready cycles, and optionally for driver_ready
    task automatic wait_for(input string what, input int bits, input int readies,
                            input bit idle);
        int n;
        n = 0;
        while ((captured.size() < bits || ready_cycles < readies || (idle && !driver_ready))
               && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("%s: the driver did not finish within %0d cycles", what, WAIT_LIMIT);
            test_errors++;
        end
    endtask

    task automatic check_word(input string name, input led_driver_pkg::lane_word_t expected,
                              input led_driver_pkg::lane_word_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s, %s: expected %h, actual %h", current_test, name,
                     expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH %s, %s: expected %b, actual %b", current_test, name,
                     expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("MISMATCH %s, %s: expected %0d, actual %0d", current_test, name,
                     expected, actual);
            test_errors++;
        end
    endtask

    task automatic compare_column(input string name, input int which, input int first);
        check_count($sformatf("%s bit count", name), led_driver_pkg::COLUMN_BITS,
                    captured.size() - first);
        for (int i = 0; i < led_driver_pkg::COLUMN_BITS && first + i < captured.size(); i++) begin
            check_word($sformatf("%s bit %0d", name, i), written[which][i], captured[first + i]);
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("%-20s passed", name);
        end else begin
            $display("%-20s failed with %0d errors", name, test_errors);
            failed_tests++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    task automatic reset_values();
        current_test = "reset";
        check_bit("sclk after reset", 1'b0, drv_sclk);
        check_bit("lat after reset", 1'b0, drv_lat);
        check_bit("gclk after reset", 1'b0, drv_gclk);
        check_bit("column_ready after reset", 1'b0, column_ready);
        check_bit("driver_ready after reset", 1'b0, driver_ready);
        repeat (10 * BIT_CLOCKS) next_cycle();
        check_count("gclk rises before configuration", 0, gclk_rises);
        finish_test("reset");
    endtask

    task automatic configuration_shift();
        int first;
        int lat0;
        logic [led_driver_pkg::CONF_BITS-1:0] conf;
        current_test = "configuration";
        first = captured.size();
        lat0 = lat_pulses;
        conf = led_driver_pkg::CONF_WORD;
        new_configuration_ready = 1'b1;
        next_cycle();
        new_configuration_ready = 1'b0;
        wait_for("configuration", first + led_driver_pkg::CONF_BITS, 0, 1'b1);
        check_count("configuration bit count", led_driver_pkg::CONF_BITS,
                    captured.size() - first);
        // MSB first, same bit on every lane
        for (int i = 0; i < led_driver_pkg::CONF_BITS && first + i < captured.size(); i++) begin
            check_word($sformatf("configuration bit %0d", i),
                       {led_driver_pkg::LANES{conf[led_driver_pkg::CONF_BITS-1]}},
                       captured[first + i]);
            conf = conf << 1;
        end
        check_count("configuration latch pulses", 1, lat_pulses - lat0);
        check_bit("driver_ready after configuration", 1'b1, driver_ready);
        finish_test("configuration");
    endtask

    task automatic column_stream();
        int first;
        int lat0;
        int rdy0;
        current_test = "column stream";
        write_column(0);
        first = captured.size();
        lat0 = lat_pulses;
        rdy0 = ready_cycles;
        pulse_sync();
        wait_for("column stream", first + led_driver_pkg::COLUMN_BITS, rdy0 + 1, 1'b1);
        repeat (4) next_cycle();
        compare_column("column", 0, first);
        check_count("column latch pulses", 1, lat_pulses - lat0);
        check_count("column_ready cycles", 1, ready_cycles - rdy0);
        finish_test("column stream");
    endtask

    task automatic bank_independence();
        int first;
        int rdy0;
        current_test = "bank independence";
        write_column(0);
        first = captured.size();
        rdy0 = ready_cycles;
        pulse_sync();
        // Back bank refilled while the front bank shifts
        wait_for("bank A start", first + 4, 0, 1'b0);
        write_column(1);
        wait_for("bank A", first + led_driver_pkg::COLUMN_BITS, rdy0 + 1, 1'b1);
        compare_column("bank A", 0, first);
        first = captured.size();
        pulse_sync();
        wait_for("bank B", first + led_driver_pkg::COLUMN_BITS, rdy0 + 2, 1'b1);
        compare_column("bank B", 1, first);
        finish_test("bank independence");
    endtask

    task automatic sync_while_busy();
        int first;
        int lat0;
        int rdy0;
        current_test = "sync while busy";
        first = captured.size();
        lat0 = lat_pulses;
        rdy0 = ready_cycles;
        pulse_sync();
        wait_for("second sync", first + 4, 0, 1'b0);
        pulse_sync();
        wait_for("third sync", first + 12, 0, 1'b0);
        pulse_sync();
        wait_for("busy columns", first + 2 * led_driver_pkg::COLUMN_BITS, rdy0 + 2, 1'b1);
        // Room for a third column if one were wrongly queued
        repeat ((led_driver_pkg::COLUMN_BITS + 4) * BIT_CLOCKS) next_cycle();
        check_count("columns after three syncs", 2, ready_cycles - rdy0);
        check_count("latches after three syncs", 2, lat_pulses - lat0);
        check_count("bits after three syncs", 2 * led_driver_pkg::COLUMN_BITS,
                    captured.size() - first);
        finish_test("sync while busy");
    endtask

    task automatic grayscale_clock();
        int rises0;
        int rises;
        int expected;
        current_test = "grayscale clock";
        rises0 = gclk_rises;
        expected = 400 / BIT_CLOCKS;
        repeat (400) next_cycle();
        rises = gclk_rises - rises0;
        if (rises < expected - 1 || rises > expected + 1) begin
            $display("MISMATCH %s, gclk rises in 400 clocks: expected %0d +/- 1, actual %0d",
                     current_test, expected, rises);
            test_errors++;
        end
        finish_test("grayscale clock");
    endtask

    initial begin
        new_configuration_ready = 1'b0;
        position_sync = 1'b0;
        buf_we = 1'b0;
        buf_addr = '0;
        buf_wdata = '0;
        wait (nrst === 1'b1);
        next_cycle();
        reset_values();
        configuration_shift();
        column_stream();
        bank_independence();
        sync_while_busy();
        grayscale_clock();
        $display("6 tests, %0d failed, %0d errors in total", failed_tests, total_errors);
        if (total_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- led_wall.f
common/led_driver_pkg.sv
src/clock_enable.sv
src/column_buffer.sv
driver/driver_serializer.sv
driver/driver_controller.sv
driver/gclk_generator.sv
src/led_wall.sv
bench/tb_clock.sv
bench/led_wall_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f led_wall.f --top-module led_wall_tb

sim:
	verilator --binary --timing --assert -f led_wall.f --top-module led_wall_tb -o led_wall_sim
	./obj_dir/led_wall_sim | tee $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
